//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memStageTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/cacheArray.sv
// cache storage array
// one payload type per instance, written on the clock edge and read
// without a clock, so lookups resolve in the same cycle

`timescale 1ns/1ns
`default_nettype none

module cacheArray #(
   parameter int  indexBits = 4,
   parameter type entryT    = logic
) (
   input  wire                  CLK,
   input  wire                  wrEn,
   input  wire [indexBits-1:0]  wrIndex,
   input  wire entryT           wrEntry,
   input  wire [indexBits-1:0]  rdIndex,
   output entryT                rdEntry
);

   // one entry per set, or per word when the index carries the offset
   entryT entries [2**indexBits];

   always_ff @(posedge CLK) begin
      if (wrEn) begin
         entries[wrIndex] <= wrEntry;
      end
   end

   // asynchronous read port
   assign rdEntry = entries[rdIndex];

endmodule

`default_nettype wire

//--- design/dataCache.sv
// direct-mapped write-back data cache
// load hits in the same cycle, store hits merged into the stored word
// one cycle later, dirty victims written out before the line refill

`timescale 1ns/1ns
`default_nettype none

module dataCache #(
   parameter int indexBits  = 4,
   parameter int offsetBits = 2
) (
   input  wire                       CLK,
   input  wire                       MRST,
   input  wire memStagePkg::dataReqT dataReq,
   output memStagePkg::wordT         loadData,
   output logic                      dStall,
   output memStagePkg::busReqT       busReq,
   input  wire                       grant,
   input  wire                       memValid,
   input  wire memStagePkg::wordT    memRdData
);
   import memStagePkg::*;

   localparam int tagBits = 32 - indexBits - offsetBits - 2;

   typedef struct packed {
      logic               valid;
      logic               dirty;
      logic [tagBits-1:0] tag;
   } tagEntryT;

   typedef enum logic [2:0] {idle, storeHit, writeBack, waitMem, refill} stateT;

   stateT                           state;
   logic [offsetBits-1:0]           lineOffset;
   logic                            sweeping;
   logic [indexBits-1:0]            sweepIdx;
   // store held over for the storeHit cycle
   logic [indexBits+offsetBits-1:0] stWordIdx;
   wordT                            stWord;

   logic [tagBits-1:0]              addrTag;
   logic [indexBits-1:0]            addrIdx;
   logic [offsetBits-1:0]           addrOff;
   tagEntryT                        tagRd;
   tagEntryT                        tagWr;
   logic                            tagWe;
   wordT                            wordRd;
   logic                            active;
   logic                            hit;
   logic                            storeHitNow;
   logic                            wordIn;
   logic                            lastWord;
   logic [4:0]                      laneShift;
   wordT                            laneMask;
   wordT                            merged;

   assign addrTag = dataReq.addr[31 -: tagBits];
   assign addrIdx = dataReq.addr[offsetBits+2 +: indexBits];
   assign addrOff = dataReq.addr[2 +: offsetBits];

   // ----------------------------------------
   // arrays
   // ----------------------------------------

   cacheArray #(.indexBits(indexBits), .entryT(tagEntryT)) tagArray (
      .CLK     (CLK),
      .wrEn    (tagWe),
      .wrIndex (sweeping ? sweepIdx : addrIdx),
      .wrEntry (tagWr),
      .rdIndex (addrIdx),
      .rdEntry (tagRd)
   );

   // write-back walks the victim line, everything else reads the request word
   cacheArray #(.indexBits(indexBits + offsetBits), .entryT(wordT)) dataArray (
      .CLK     (CLK),
      .wrEn    ((state == storeHit) | wordIn),
      .wrIndex ((state == storeHit) ? stWordIdx : {addrIdx, lineOffset}),
      .wrEntry ((state == storeHit) ? stWord : memRdData),
      .rdIndex ((state == writeBack) ? {addrIdx, lineOffset} : {addrIdx, addrOff}),
      .rdEntry (wordRd)
   );

   // ----------------------------------------
   // lookup and store merge
   // ----------------------------------------

   assign active      = dataReq.isLoad | dataReq.isStore;
   assign hit         = tagRd.valid & (tagRd.tag == addrTag);
   assign storeHitNow = (state == idle) & ~sweeping & dataReq.isStore & hit;
   assign wordIn      = grant & memValid & ((state == waitMem) | (state == refill));
   assign lastWord    = (lineOffset == '1);
   // storeHit stalls whatever comes next, so the merged word lands first
   assign dStall      = sweeping | (state == storeHit) | (active & (~hit | (state != idle)));
   assign loadData    = dataReq.isLoad ? wordRd : '0;

   // big-endian lanes, byte address 0 is the top byte of the word
   always_comb begin
      case (dataReq.size)
         sizeByte: begin
            laneShift = {~dataReq.addr[1:0], 3'b000};
            laneMask  = 32'h0000_00ff << laneShift;
         end
         sizeHalf: begin
            laneShift = {~dataReq.addr[1], 4'b0000};
            laneMask  = 32'h0000_ffff << laneShift;
         end
         default: begin
            laneShift = 5'd0;
            laneMask  = '1;
         end
      endcase
      merged = (wordRd & ~laneMask) | ((dataReq.storeData << laneShift) & laneMask);
   end

   // tag updates
   // store hit sets dirty from idle, write-back end cleans the victim,
   // refill end installs the new tag
   assign tagWe = sweeping | storeHitNow | (wordIn & lastWord)
                | ((state == writeBack) & grant & lastWord);

   always_comb begin
      tagWr.valid = ~sweeping;
      tagWr.dirty = ~sweeping & (state == idle);
      tagWr.tag   = (state == writeBack) ? tagRd.tag : addrTag;
   end

   // ----------------------------------------
   // bus request
   // ----------------------------------------

   always_comb begin
      busReq.read   = (state == waitMem) | (state == refill);
      busReq.write  = (state == writeBack);
      busReq.wrData = wordRd;
      if (state == writeBack) begin
         busReq.addr = {tagRd.tag, addrIdx, lineOffset, 2'b00};
      end else begin
         busReq.addr = {addrTag, addrIdx, {(offsetBits + 2){1'b0}}};
      end
   end

   // capture the merged store word
   always_ff @(posedge CLK) begin
      if (storeHitNow) begin
         stWordIdx <= {addrIdx, addrOff};
         stWord    <= merged;
      end
   end

   // cache FSM and reset sweep
   always_ff @(posedge CLK) begin
      if (MRST) begin
         state      <= idle;
         lineOffset <= '0;
         sweeping   <= 1'b1;
         sweepIdx   <= '0;
      end else begin
         if (sweeping) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == '1) begin
               sweeping <= 1'b0;
            end
         end
         case (state)
            idle: begin
               if (!sweeping && active && !hit) begin
                  // dirty victim goes out first, the miss is seen again after
                  state <= (tagRd.valid && tagRd.dirty) ? writeBack : waitMem;
               end else if (storeHitNow) begin
                  state <= storeHit;
               end
            end
            storeHit: state <= idle;
            // one word per granted cycle, memory never pushes back
            writeBack: begin
               if (grant) begin
                  lineOffset <= lineOffset + 1'b1;
                  if (lastWord) begin
                     state <= idle;
                  end
               end
            end
            waitMem, refill: begin
               if (wordIn) begin
                  lineOffset <= lineOffset + 1'b1;
                  state      <= lastWord ? idle : refill;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/instCache.sv
// direct-mapped instruction cache
// hit lookup against fetchAddr in the same cycle, line refill over the
// shared word bus, and a reset sweep that invalidates every set

`timescale 1ns/1ns
`default_nettype none

module instCache #(
   parameter int indexBits  = 4,
   parameter int offsetBits = 2
) (
   input  wire                     CLK,
   input  wire                     MRST,
   input  wire memStagePkg::addrT  fetchAddr,
   output memStagePkg::wordT       instr,
   output logic                    iStall,
   output memStagePkg::busReqT     busReq,
   input  wire                     grant,
   input  wire                     memValid,
   input  wire memStagePkg::wordT  memRdData
);
   import memStagePkg::*;

   localparam int tagBits = 32 - indexBits - offsetBits - 2;

   typedef struct packed {
      logic               valid;
      logic [tagBits-1:0] tag;
   } tagEntryT;

   typedef enum logic [1:0] {idle, waitMem, refill} stateT;

   stateT                 state;
   logic [offsetBits-1:0] lineOffset;
   logic                  sweeping;
   logic [indexBits-1:0]  sweepIdx;

   logic [tagBits-1:0]    addrTag;
   logic [indexBits-1:0]  addrIdx;
   logic [offsetBits-1:0] addrOff;
   tagEntryT              tagRd;
   tagEntryT              tagWr;
   wordT                  wordRd;
   logic                  hit;
   logic                  wordIn;
   logic                  lastWord;

   // split the fetch address
   assign addrTag = fetchAddr[31 -: tagBits];
   assign addrIdx = fetchAddr[offsetBits+2 +: indexBits];
   assign addrOff = fetchAddr[2 +: offsetBits];

   // ----------------------------------------
   // arrays
   // ----------------------------------------

   // sweep clears entries, refill writes the tag with the last word
   cacheArray #(.indexBits(indexBits), .entryT(tagEntryT)) tagArray (
      .CLK     (CLK),
      .wrEn    (sweeping | (wordIn & lastWord)),
      .wrIndex (sweeping ? sweepIdx : addrIdx),
      .wrEntry (tagWr),
      .rdIndex (addrIdx),
      .rdEntry (tagRd)
   );

   cacheArray #(.indexBits(indexBits + offsetBits), .entryT(wordT)) dataArray (
      .CLK     (CLK),
      .wrEn    (wordIn),
      .wrIndex ({addrIdx, lineOffset}),
      .wrEntry (memRdData),
      .rdIndex ({addrIdx, addrOff}),
      .rdEntry (wordRd)
   );

   always_comb begin
      tagWr.valid = ~sweeping;
      tagWr.tag   = addrTag;
   end

   // ----------------------------------------
   // lookup and bus request
   // ----------------------------------------

   assign hit      = tagRd.valid & (tagRd.tag == addrTag);
   assign iStall   = sweeping | (state != idle) | ~hit;
   assign instr    = iStall ? '0 : wordRd;
   // valid only reaches the bus owner
   assign wordIn   = grant & memValid & (state != idle);
   assign lastWord = (lineOffset == '1);

   // read held at the line base until the last word is in
   always_comb begin
      busReq.read   = (state != idle);
      busReq.write  = 1'b0;
      busReq.addr   = {fetchAddr[31:offsetBits+2], {(offsetBits + 2){1'b0}}};
      busReq.wrData = '0;
   end

   // refill FSM and reset sweep
   always_ff @(posedge CLK) begin
      if (MRST) begin
         state      <= idle;
         lineOffset <= '0;
         sweeping   <= 1'b1;
         sweepIdx   <= '0;
      end else begin
         if (sweeping) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == '1) begin
               sweeping <= 1'b0;
            end
         end
         case (state)
            idle: begin
               if (!sweeping && !hit) begin
                  state <= waitMem;
               end
            end
            // first word moves on to refill, last word back to idle
            waitMem, refill: begin
               if (wordIn) begin
                  lineOffset <= lineOffset + 1'b1;
                  state      <= lastWord ? idle : refill;
               end
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/memBusArbiter.sv
// word bus arbiter for the two caches
// data cache wins ties, ownership holds while the owner keeps read or
// write up; also merges the cache stalls into the pipeline inhibits

`timescale 1ns/1ns
`default_nettype none

module memBusArbiter (
   input  wire                      CLK,
   input  wire                      MRST,
   input  wire memStagePkg::busReqT iBusReq,
   input  wire memStagePkg::busReqT dBusReq,
   input  wire                      iStall,
   input  wire                      dStall,
   output logic                     iGrant,
   output logic                     dGrant,
   output logic                     iMemValid,
   output logic                     dMemValid,
   input  wire                      memValid,
   output logic                     memRead,
   output logic                     memWrite,
   output memStagePkg::addrT        memAddr,
   output memStagePkg::wordT        memWrData,
   output logic                     pipeInhibit,
   output logic                     pcInhibit
);
   import memStagePkg::*;

   typedef enum logic [1:0] {busIdle, busInst, busData} ownerT;

   ownerT  owner;
   busReqT sel;

   // ownership only changes hands through busIdle
   always_ff @(posedge CLK) begin
      if (MRST) begin
         owner <= busIdle;
      end else begin
         case (owner)
            busIdle: begin
               if (dBusReq.read || dBusReq.write) begin
                  owner <= busData;
               end else if (iBusReq.read || iBusReq.write) begin
                  owner <= busInst;
               end
            end
            busInst: if (!(iBusReq.read || iBusReq.write)) owner <= busIdle;
            busData: if (!(dBusReq.read || dBusReq.write)) owner <= busIdle;
            default: owner <= busIdle;
         endcase
      end
   end

   assign iGrant = (owner == busInst);
   assign dGrant = (owner == busData);

   // ----------------------------------------
   // bus mux and valid steering
   // ----------------------------------------

   assign sel       = dGrant ? dBusReq : iBusReq;
   assign memRead   = (iGrant | dGrant) & sel.read;
   assign memWrite  = (iGrant | dGrant) & sel.write;
   assign memAddr   = sel.addr;
   assign memWrData = sel.wrData;
   assign iMemValid = iGrant & memValid;
   assign dMemValid = dGrant & memValid;

   // pipeline inhibits
   assign pipeInhibit = iStall | dStall;

   always_ff @(posedge CLK) begin
      if (MRST) begin
         pcInhibit <= 1'b0;
      end else begin
         pcInhibit <= pipeInhibit;
      end
   end

endmodule

`default_nettype wire

//--- design/memStage.sv
// memory stage top level
// instruction cache and data cache side by side, sharing one external
// word bus through the arbiter

`timescale 1ns/1ns
`default_nettype none

module memStage #(
   parameter int offsetBits = memStagePkg::defaultOffsetBits,
   parameter int iIndexBits = memStagePkg::defaultIIndexBits,
   parameter int dIndexBits = memStagePkg::defaultDIndexBits
) (
   input  wire                       CLK,
   input  wire                       MRST,
   input  wire memStagePkg::addrT    fetchAddr,
   output memStagePkg::wordT         instr,
   input  wire memStagePkg::dataReqT dataReq,
   output memStagePkg::wordT         loadData,
   output logic                      memRead,
   output logic                      memWrite,
   output memStagePkg::addrT         memAddr,
   output memStagePkg::wordT         memWrData,
   input  wire memStagePkg::wordT    memRdData,
   input  wire                       memValid,
   output logic                      pipeInhibit,
   output logic                      pcInhibit
);
   import memStagePkg::*;

   // cache to arbiter wiring
   logic   iStall;
   logic   dStall;
   logic   iGrant;
   logic   dGrant;
   logic   iMemValid;
   logic   dMemValid;
   busReqT iBusReq;
   busReqT dBusReq;

   instCache #(.indexBits(iIndexBits), .offsetBits(offsetBits)) iCache (
      .CLK       (CLK),
      .MRST      (MRST),
      .fetchAddr (fetchAddr),
      .instr     (instr),
      .iStall    (iStall),
      .busReq    (iBusReq),
      .grant     (iGrant),
      .memValid  (iMemValid),
      .memRdData (memRdData)
   );

   dataCache #(.indexBits(dIndexBits), .offsetBits(offsetBits)) dCache (
      .CLK       (CLK),
      .MRST      (MRST),
      .dataReq   (dataReq),
      .loadData  (loadData),
      .dStall    (dStall),
      .busReq    (dBusReq),
      .grant     (dGrant),
      .memValid  (dMemValid),
      .memRdData (memRdData)
   );

   memBusArbiter arbiter (
      .CLK         (CLK),
      .MRST        (MRST),
      .iBusReq     (iBusReq),
      .dBusReq     (dBusReq),
      .iStall      (iStall),
      .dStall      (dStall),
      .iGrant      (iGrant),
      .dGrant      (dGrant),
      .iMemValid   (iMemValid),
      .dMemValid   (dMemValid),
      .memValid    (memValid),
      .memRead     (memRead),
      .memWrite    (memWrite),
      .memAddr     (memAddr),
      .memWrData   (memWrData),
      .pipeInhibit (pipeInhibit),
      .pcInhibit   (pcInhibit)
   );

endmodule

`default_nettype wire

//--- design/memStagePkg.sv
// memory stage shared types
// words, addresses, access sizes and the two request structs used by
// the pipeline interface and the word bus between caches and arbiter

`default_nettype none

package memStagePkg;

   // ----------------------------------------
   // basic words
   // ----------------------------------------

   // data or instruction word
   typedef logic [31:0] wordT;

   // byte address
   typedef logic [31:0] addrT;

   // width of a load or store
   typedef enum logic [1:0] {
      sizeByte = 2'd0,
      sizeHalf = 2'd1,
      sizeWord = 2'd2
   } accessSizeT;

   // ----------------------------------------
   // request structs
   // ----------------------------------------

   // decoded stage 4 request, inactive when both isLoad and isStore are low
   typedef struct packed {
      logic       isLoad;
      logic       isStore;
      accessSizeT size;
      addrT       addr;
      // value sits in the low bits for byte and half stores
      wordT       storeData;
   } dataReqT;

   // one cache's view of the word bus
   typedef struct packed {
      logic read;
      logic write;
      addrT addr;
      wordT wrData;
   } busReqT;

   // defaults for the top level geometry
   // 4 words per line and 16 sets in each cache
   localparam int defaultOffsetBits = 2;
   localparam int defaultIIndexBits = 4;
   localparam int defaultDIndexBits = 4;

endpackage

`default_nettype wire

//--- test/memBusArbiter_assertions.sv
// bus protocol checks for the word bus arbiter
// bound into every arbiter instance, checked on the rising clock edge

`timescale 1ns/1ns
`default_nettype none

module memBusArbiter_assertions (
   input wire CLK,
   input wire MRST,
   input wire iGrant,
   input wire dGrant,
   input wire memRead,
   input wire memWrite,
   input wire pipeInhibit,
   input wire pcInhibit
);

   // failed assertions so far, read by the testbench top
   int failCount = 0;

   // one direction at a time on the bus
   readWriteExclusive: assert property (@(posedge CLK) disable iff (MRST)
      !(memRead && memWrite))
      else begin
         failCount++;
         $error("memRead and memWrite high together");
      end

   // only the data cache ever writes
   writeOnlyByData: assert property (@(posedge CLK) disable iff (MRST)
      memWrite |-> dGrant)
      else begin
         failCount++;
         $error("memWrite high without the data cache grant");
      end

   grantsExclusive: assert property (@(posedge CLK) disable iff (MRST)
      !(iGrant && dGrant))
      else begin
         failCount++;
         $error("both caches granted at once");
      end

   // first cycle out of reset still holds the reset value
   pcFollowsPipe: assert property (@(posedge CLK) disable iff (MRST)
      !$past(MRST) |-> (pcInhibit == $past(pipeInhibit)))
      else begin
         failCount++;
         $error("pcInhibit does not follow pipeInhibit by one cycle");
      end

endmodule

`default_nettype wire

//--- test/memStageTb.sv
// memory stage testbench
// fixed-seed random fetches, loads and stores checked against a reference
// model, with a bus memory that answers refills with gaps and takes writes

`timescale 1ns/1ns
`default_nettype none

module memStageTb;
   import memStagePkg::*;

   typedef logic [11:0] memIdxT;

   localparam int   seedVal   = 2;
   localparam int   memWords  = 4096;
   // data below instBase, instructions above it
   localparam addrT instBase  = 32'h0000_2000;
   // top lines of each region stay cold for the arbitration test
   localparam addrT arbData   = 32'h0000_1f00;
   localparam addrT arbInst   = 32'h0000_3f00;
   localparam addrT regionLen = 32'h0000_1f00;
   localparam int   nFetch    = 40;
   localparam int   nLoad     = 40;
   localparam int   nStore    = 30;
   localparam int   nEvict    = 8;
   localparam int   nArb      = 8;
   localparam int   nRequests = 2 * nFetch + 2 * nLoad + 3 * nStore + 4 * nEvict + nArb;
   localparam int   maxCycles = 40 * nRequests + 2000;

   logic    CLK;
   logic    MRST;
   addrT    fetchAddr;
   wordT    instr;
   dataReqT dataReq;
   wordT    loadData;
   logic    memRead;
   logic    memWrite;
   addrT    memAddr;
   wordT    memWrData;
   wordT    memRdData;
   logic    memValid;
   logic    pipeInhibit;
   logic    pcInhibit;

   // bus memory and the value each word should read
   wordT    busMem [memWords];
   wordT    refMem [memWords];
   addrT    xferLog [$];
   int      busReads;
   int      busWrites;
   int      errCount    = 0;
   int      checkCount  = 0;
   int      markErrs    = 0;
   int      failedTests = 0;
   int      inhibitErrs = 0;
   int      cycles      = 0;
   logic    prevPipe    = 1'b1;
   logic    prevRst     = 1'b1;

   tbClock #(.period(8)) clkGen (.CLK(CLK));

   memStage #(
      .offsetBits (defaultOffsetBits),
      .iIndexBits (defaultIIndexBits),
      .dIndexBits (defaultDIndexBits)
   ) i_dut (
      .CLK         (CLK),
      .MRST        (MRST),
      .fetchAddr   (fetchAddr),
      .instr       (instr),
      .dataReq     (dataReq),
      .loadData    (loadData),
      .memRead     (memRead),
      .memWrite    (memWrite),
      .memAddr     (memAddr),
      .memWrData   (memWrData),
      .memRdData   (memRdData),
      .memValid    (memValid),
      .pipeInhibit (pipeInhibit),
      .pcInhibit   (pcInhibit)
   );

   bind memBusArbiter memBusArbiter_assertions arbChecks (
      .CLK         (CLK),
      .MRST        (MRST),
      .iGrant      (iGrant),
      .dGrant      (dGrant),
      .memRead     (memRead),
      .memWrite    (memWrite),
      .pipeInhibit (pipeInhibit),
      .pcInhibit   (pcInhibit)
   );

   // initial memory contents, unique for every word address
   function automatic wordT fillWord(input memIdxT idx);
      return {4'ha, idx, 4'h5, ~idx};
   endfunction

   function automatic memIdxT wordIdx(input addrT a);
      return a[13:2];
   endfunction

   // random address in [base, base + span), aligned to align bytes
   function automatic addrT randAddr(input addrT base, input addrT span, input addrT align);
      addrT off;
      off = $urandom % span;
      return base + (off & ~(align - 1));
   endfunction

   function automatic accessSizeT randSize();
      case ($urandom % 3)
         0: return sizeByte;
         1: return sizeHalf;
         default: return sizeWord;
      endcase
   endfunction

   function automatic addrT sizeAlign(input accessSizeT sz);
      case (sz)
         sizeByte: return 32'd1;
         sizeHalf: return 32'd2;
         default: return 32'd4;
      endcase
   endfunction

   function automatic dataReqT makeReq(input logic ld, input logic st, input accessSizeT sz,
                                       input addrT a, input wordT d);
      dataReqT r;
      r.isLoad    = ld;
      r.isStore   = st;
      r.size      = sz;
      r.addr      = a;
      r.storeData = d;
      return r;
   endfunction

   // MIPS big-endian lanes, byte 0 of a word is bits 31:24
   function automatic wordT mergeStore(input wordT old, input dataReqT req);
      wordT res;
      int   lane;
      res  = old;
      lane = int'(req.addr[1:0]);
      case (req.size)
         sizeByte: res[31 - 8 * lane -: 8] = req.storeData[7:0];
         sizeHalf: res[31 - 8 * lane -: 16] = req.storeData[15:0];
         default: res = req.storeData;
      endcase
      return res;
   endfunction

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      checkCount++;
      assert (got == exp) else begin
         $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errCount++;
      end
   endtask

   task automatic checkTrue(input logic cond, input string what);
      checkCount++;
      assert (cond) else begin
         $display("error at %0t ns: %s", $time, what);
         errCount++;
      end
   endtask

   task automatic reportTest(input string name);
      int fails;
      fails = errCount - markErrs;
      if (fails == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: FAILED with %0d errors", name, fails);
         failedTests++;
      end
      markErrs = errCount;
   endtask

   // present one fetch and one data request, check them once the pipeline may move
   task automatic runRequest(input addrT fAddr, input dataReqT req, output int waits);
      wordT expLoad;
      @(negedge CLK);
      fetchAddr = fAddr;
      dataReq   = req;
      waits     = 0;
      @(posedge CLK);
      while (pipeInhibit) begin
         waits++;
         @(posedge CLK);
      end
      expLoad = req.isLoad ? refMem[wordIdx(req.addr)] : '0;
      checkWord("instr", instr, refMem[wordIdx(fAddr)]);
      checkWord("loadData", loadData, expLoad);
      if (req.isStore) begin
         refMem[wordIdx(req.addr)] = mergeStore(refMem[wordIdx(req.addr)], req);
      end
   endtask

   // ----------------------------------------
   // bus memory
   // ----------------------------------------

   // takes writes and counts refill words on the rising edge,
   // offers the next refill word with random gaps on the falling edge
   initial begin
      logic   busyPrev;
      logic   [1:0] rdCount;
      memIdxT rdBase;
      busyPrev  = 1'b0;
      rdCount   = 2'd0;
      busReads  = 0;
      busWrites = 0;
      memValid  = 1'b0;
      memRdData = '0;
      for (int i = 0; i < memWords; i++) begin
         busMem[i] = fillWord(i[11:0]);
      end
      forever begin
         @(posedge CLK);
         if ((memRead || memWrite) && !busyPrev) begin
            xferLog.push_back(memAddr);
         end
         busyPrev = memRead || memWrite;
         if (memWrite) begin
            busMem[wordIdx(memAddr)] <= memWrData;
            busWrites <= busWrites + 1;
         end
         if (memRead) begin
            busReads <= busReads + 1;
            if (memValid) begin
               rdCount = rdCount + 2'd1;
            end
         end else begin
            rdCount = 2'd0;
         end
         @(negedge CLK);
         rdBase = wordIdx(memAddr);
         if (memRead && ($urandom % 3 != 0)) begin
            memValid  <= 1'b1;
            memRdData <= busMem[rdBase + {10'b0, rdCount}];
         end else begin
            memValid  <= 1'b0;
            memRdData <= $urandom;
         end
      end
   end

   // pcInhibit tracking and the run limit
   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (!MRST && !prevRst) begin
         assert (pcInhibit == prevPipe) else begin
            $display("error at %0t ns: pcInhibit is %b, expected %b", $time, pcInhibit, prevPipe);
            inhibitErrs <= inhibitErrs + 1;
         end
      end
      prevPipe <= pipeInhibit;
      prevRst  <= MRST;
      if (cycles >= maxCycles) begin
         $display("run stopped after %0d cycles, the DUT stopped completing requests", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   // ----------------------------------------
   // test sequence
   // ----------------------------------------

   initial begin
      int         waits;
      int         reads;
      int         writes;
      int         logStart;
      logic       rstOk;
      addrT       fa;
      addrT       da;
      addrT       sa;
      addrT       ca;
      addrT       curFetch;
      accessSizeT sz;
      void'($urandom(seedVal));
      MRST      = 1'b1;
      fetchAddr = instBase;
      dataReq   = '0;
      for (int i = 0; i < memWords; i++) begin
         refMem[i] = fillWord(i[11:0]);
      end
      repeat (10) @(posedge CLK);
      @(negedge CLK);
      MRST = 1'b0;
      @(posedge CLK);
      rstOk = !pcInhibit && !memRead && !memWrite;

      // fetch, then another word of the same line
      curFetch = instBase;
      for (int i = 0; i < nFetch; i++) begin
         fa = randAddr(instBase, regionLen, 32'd4);
         runRequest(fa, '0, waits);
         reads    = busReads;
         curFetch = (fa & ~32'hf) | randAddr(32'd0, 32'd16, 32'd4);
         runRequest(curFetch, '0, waits);
         checkTrue(busReads == reads && waits == 0, "repeated fetch of a cached line missed");
      end
      reportTest("fetch");

      for (int i = 0; i < nLoad; i++) begin
         da = randAddr(32'd0, regionLen, 32'd4);
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, da, '0), waits);
         reads = busReads;
         sa    = (da & ~32'hf) | randAddr(32'd0, 32'd16, 32'd4);
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, sa, '0), waits);
         checkTrue(busReads == reads && waits == 0, "load after a refill of its line missed");
      end
      reportTest("load");

      // load brings the line in, so the store always hits
      for (int i = 0; i < nStore; i++) begin
         da = randAddr(32'd0, regionLen, 32'd4);
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, da, '0), waits);
         sz = randSize();
         sa = da + randAddr(32'd0, 32'd4, sizeAlign(sz));
         runRequest(curFetch, makeReq(1'b0, 1'b1, sz, sa, $urandom), waits);
         checkTrue(waits == 0, "store hit was held before it was accepted");
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, da, '0), waits);
         checkTrue(waits == 1, "store hit did not inhibit the pipeline for exactly one cycle");
      end
      reportTest("store");

      for (int i = 0; i < nEvict; i++) begin
         da = randAddr(32'd0, regionLen, 32'd4);
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, da, '0), waits);
         sz = randSize();
         sa = da + randAddr(32'd0, 32'd4, sizeAlign(sz));
         runRequest(curFetch, makeReq(1'b0, 1'b1, sz, sa, $urandom), waits);
         writes = busWrites;
         // same set, another tag inside the data region
         ca = ((((da >> 8) + 1 + ($urandom % 30)) % 31) << 8) | (da & 32'hff);
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, ca, '0), waits);
         checkTrue(busWrites - writes == 4, "dirty victim was not written back as a full line");
         for (int w = 0; w < 4; w++) begin
            sa = (da & ~32'hf) | addrT'(4 * w);
            checkWord($sformatf("bus memory word %h", sa), busMem[wordIdx(sa)],
                      refMem[wordIdx(sa)]);
         end
         runRequest(curFetch, makeReq(1'b1, 1'b0, sizeWord, da, '0), waits);
      end
      reportTest("evict");

      // cold lines in both caches, missed in the same cycle
      for (int i = 0; i < nArb; i++) begin
         fa       = arbInst + addrT'(16 * i) + randAddr(32'd0, 32'd16, 32'd4);
         da       = arbData + addrT'(16 * i) + randAddr(32'd0, 32'd16, 32'd4);
         logStart = xferLog.size();
         runRequest(fa, makeReq(1'b1, 1'b0, sizeWord, da, '0), waits);
         curFetch = fa;
         if (xferLog.size() - logStart >= 2) begin
            checkTrue(xferLog[logStart] < instBase,
                      "instruction refill took the bus before the data cache");
         end else begin
            checkTrue(1'b0, "simultaneous misses did not both use the bus");
         end
      end
      reportTest("arbitration");

      @(posedge CLK);
      checkTrue(rstOk, "pcInhibit or a bus strobe was high right after reset");
      checkTrue(!pipeInhibit && !pcInhibit, "inhibits stayed high with the caches idle");
      checkCount++;
      errCount += inhibitErrs;
      // bus protocol assertions bound into the arbiter
      errCount += i_dut.arbiter.arbChecks.failCount;
      reportTest("inhibit");

      $display("6 tests, %0d failed, %0d checks, %0d errors",
               failedTests, checkCount, errCount);
      if (errCount == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/tbClock.sv
// testbench clock source
// free running from time zero, low for the first half period

`timescale 1ns/1ns
`default_nettype none

module tbClock #(
   parameter int period = 8
) (
   output logic CLK
);

   // toggle every half period
   initial begin
      CLK = 1'b0;
      forever begin
         #(period / 2) CLK = ~CLK;
      end
   end

endmodule

`default_nettype wire

//--- verilog.f
design/memStagePkg.sv
design/cacheArray.sv
design/instCache.sv
design/dataCache.sv
design/memBusArbiter.sv
design/memStage.sv
test/tbClock.sv
test/memBusArbiter_assertions.sv
test/memStageTb.sv
